// File: hw/isa_pkg.sv
package isa_pkg;

  // byte distance to the sequential next instruction
  parameter int unsigned pc_step = 4;

  // first fetch address out of reset
  parameter logic [31:0] reset_vector = 32'h0000_0100;

endpackage

// File: hw/btb_pkg.sv
package btb_pkg;

  // write-port command from the update unit to the BTB
  typedef enum logic [1:0] {
    op_none  = 2'b00,  // leave the table alone
    op_write = 2'b01,  // insert key, or retarget it in place
    op_kill  = 2'b10   // drop a matching entry
  } btb_op;

endpackage

// File: hw/btb.sv
module btb
  import btb_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int ENTRIES    = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [ADDR_WIDTH-1:0] a_key,
  input  logic [ADDR_WIDTH-1:0] b_key,
  input  btb_op                 wr_op,
  input  logic [ADDR_WIDTH-1:0] wr_key,
  input  logic [ADDR_WIDTH-1:0] wr_target,
  output logic                  a_hit,
  output logic [ADDR_WIDTH-1:0] a_target,
  output logic                  b_hit,
  output logic [ADDR_WIDTH-1:0] b_target
);

  localparam int IDX_W = $clog2(ENTRIES);

  logic [ADDR_WIDTH-1:0] keys    [ENTRIES];
  logic [ADDR_WIDTH-1:0] targets [ENTRIES];
  logic [ENTRIES-1:0]    valid;
  logic [IDX_W-1:0]      ptr;       // round-robin victim
  logic [IDX_W-1:0]      next_ptr;

  logic                  w_hit;
  logic [IDX_W-1:0]      a_idx;
  logic [IDX_W-1:0]      b_idx;
  logic [IDX_W-1:0]      w_idx;

  // search all valid entries, returns {hit, index}
  function automatic logic [IDX_W:0] find_entry(input logic [ADDR_WIDTH-1:0] key);
    logic [IDX_W:0] res;
    res = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      if (valid[i] && keys[i] == key) begin
        res = {1'b1, IDX_W'(i)};
      end
    end
    return res;
  endfunction

  // keys are unique among valid entries, so at most one match per port
  always_comb begin
    {a_hit, a_idx} = find_entry(a_key);
    {b_hit, b_idx} = find_entry(b_key);
    {w_hit, w_idx} = find_entry(wr_key);
  end

  assign a_target = a_hit ? targets[a_idx] : '0;
  assign b_target = b_hit ? targets[b_idx] : '0;

  assign next_ptr = (ptr == IDX_W'(ENTRIES - 1)) ? '0 : ptr + 1'b1;

  // key and target storage
  always_ff @(posedge clk) begin
    if (wr_op == op_write) begin
      if (w_hit) begin
        targets[w_idx] <= wr_target;  // retarget in place
      end else begin
        keys[ptr]    <= wr_key;
        targets[ptr] <= wr_target;
      end
    end
  end

  // valid bits and replacement pointer
  always_ff @(posedge clk) begin
    if (reset) begin
      valid <= '0;
      ptr   <= '0;
    end else begin
      case (wr_op)
        op_write: begin
          if (!w_hit) begin
            valid[ptr] <= 1'b1;
            ptr        <= next_ptr;
          end
        end
        op_kill: begin
          if (w_hit) begin
            valid[w_idx] <= 1'b0;  // pointer stays put
          end
        end
        default: begin
        end
      endcase
    end
  end

endmodule

// File: hw/pc_gen.sv
module pc_gen
  import isa_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_ready,
  input  logic                  pred_hit,
  input  logic [ADDR_WIDTH-1:0] pred_target,
  input  logic                  redirect,
  input  logic [ADDR_WIDTH-1:0] redirect_pc,
  output logic [ADDR_WIDTH-1:0] fetch_pc
);

  logic [ADDR_WIDTH-1:0] seq_pc;
  logic [ADDR_WIDTH-1:0] pred_pc;

  assign seq_pc  = fetch_pc + ADDR_WIDTH'(pc_step);
  assign pred_pc = pred_hit ? pred_target : seq_pc;  // follow the BTB on a hit

  // redirect wins over back-pressure from decode
  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_pc <= ADDR_WIDTH'(reset_vector);
    end else if (redirect) begin
      fetch_pc <= redirect_pc;
    end else if (fetch_ready) begin
      fetch_pc <= pred_pc;
    end
  end

endmodule

// File: hw/btb_update.sv
module btb_update
  import isa_pkg::*;
  import btb_pkg::*;
#(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  res_req,
  input  logic [ADDR_WIDTH-1:0] res_pc,
  input  logic                  res_taken,
  input  logic [ADDR_WIDTH-1:0] res_target,
  input  logic                  look_hit,
  input  logic [ADDR_WIDTH-1:0] look_target,
  output logic                  res_ack,
  output btb_op                 wr_op,
  output logic [ADDR_WIDTH-1:0] wr_key,
  output logic [ADDR_WIDTH-1:0] wr_target,
  output logic                  redirect,
  output logic [ADDR_WIDTH-1:0] redirect_pc
);

  logic                  act;          // the single action cycle of a request
  logic [ADDR_WIDTH-1:0] seq_pc;
  logic [ADDR_WIDTH-1:0] pred_next;
  logic [ADDR_WIDTH-1:0] actual_next;
  logic                  mispredict;

  assign act = res_req && !res_ack;

  assign seq_pc      = res_pc + ADDR_WIDTH'(pc_step);
  assign pred_next   = look_hit ? look_target : seq_pc;
  assign actual_next = res_taken ? res_target : seq_pc;
  assign mispredict  = (pred_next != actual_next);

  // table command, only in the action cycle
  always_comb begin
    wr_op = op_none;
    if (act) begin
      if (res_taken) begin
        wr_op = op_write;
      end else if (look_hit) begin
        wr_op = op_kill;  // predicted taken, went straight
      end
    end
  end

  assign wr_key    = res_pc;
  assign wr_target = res_target;

  // fetch reloads on the same edge that raises ack
  assign redirect    = act && mispredict;
  assign redirect_pc = actual_next;

  // slave side of the four-phase handshake
  always_ff @(posedge clk) begin
    if (reset) begin
      res_ack <= 1'b0;
    end else if (act) begin
      res_ack <= 1'b1;
    end else if (!res_req) begin
      res_ack <= 1'b0;  // release once req has dropped
    end
  end

endmodule

// File: hw/frontend.sv
module frontend
  import btb_pkg::*;
#(
  parameter int ADDR_WIDTH = 32,
  parameter int ENTRIES    = 8
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  fetch_ready,
  input  logic                  res_req,
  input  logic [ADDR_WIDTH-1:0] res_pc,
  input  logic                  res_taken,
  input  logic [ADDR_WIDTH-1:0] res_target,
  output logic [ADDR_WIDTH-1:0] fetch_pc,
  output logic                  fetch_pred_taken,
  output logic                  res_ack
);

  logic [ADDR_WIDTH-1:0] a_target;
  logic                  b_hit;
  logic [ADDR_WIDTH-1:0] b_target;
  btb_op                 wr_op;
  logic [ADDR_WIDTH-1:0] wr_key;
  logic [ADDR_WIDTH-1:0] wr_target;
  logic                  redirect;
  logic [ADDR_WIDTH-1:0] redirect_pc;

  // port A serves fetch, port B serves resolution
  btb #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .ENTRIES   (ENTRIES)
  ) btb0 (
    .clk      (clk),
    .reset    (reset),
    .a_key    (fetch_pc),
    .b_key    (res_pc),
    .wr_op    (wr_op),
    .wr_key   (wr_key),
    .wr_target(wr_target),
    .a_hit    (fetch_pred_taken),
    .a_target (a_target),
    .b_hit    (b_hit),
    .b_target (b_target)
  );

  pc_gen #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) pc_gen0 (
    .clk        (clk),
    .reset      (reset),
    .fetch_ready(fetch_ready),
    .pred_hit   (fetch_pred_taken),
    .pred_target(a_target),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .fetch_pc   (fetch_pc)
  );

  btb_update #(
    .ADDR_WIDTH(ADDR_WIDTH)
  ) btb_update0 (
    .clk        (clk),
    .reset      (reset),
    .res_req    (res_req),
    .res_pc     (res_pc),
    .res_taken  (res_taken),
    .res_target (res_target),
    .look_hit   (b_hit),
    .look_target(b_target),
    .res_ack    (res_ack),
    .wr_op      (wr_op),
    .wr_key     (wr_key),
    .wr_target  (wr_target),
    .redirect   (redirect),
    .redirect_pc(redirect_pc)
  );

endmodule

// File: dv/frontend_sva.sv
module resolution_sva (
  input logic clk,
  input logic reset,
  input logic res_req,
  input logic res_ack,
  input logic redirect
);

  // ack only answers a pending request
  ack_needs_req: assert property (
    @(posedge clk) disable iff (reset)
    $rose(res_ack) |-> $past(res_req)
  ) else $error("res_ack rose while res_req was low");

  // fetch reload is a single-cycle pulse
  redirect_pulse: assert property (
    @(posedge clk) disable iff (reset)
    redirect |=> !redirect
  ) else $error("redirect held for more than one cycle");

  ack_held: assert property (
    @(posedge clk) disable iff (reset)
    (res_ack && res_req) |=> res_ack
  ) else $error("res_ack dropped while res_req was still high");

endmodule

bind btb_update resolution_sva sva0 (
  .clk     (clk),
  .reset   (reset),
  .res_req (res_req),
  .res_ack (res_ack),
  .redirect(redirect)
);

// File: dv/frontend_tb.sv
module frontend_tb
  import isa_pkg::*;
;

  localparam int entries     = 8;
  localparam int idx_w       = $clog2(entries);
  localparam int max_records = 64;
  localparam int walk_limit  = 32;  // cycles a fetch check may wait
  localparam int ack_limit   = 8;

  logic        clk;
  logic        reset;
  logic        fetch_ready;
  logic        res_req;
  logic [31:0] res_pc;
  logic        res_taken;
  logic [31:0] res_target;
  logic [31:0] fetch_pc;
  logic        fetch_pred_taken;
  logic        res_ack;

  logic [31:0] stim [256];  // four words per record

  // reference model state
  logic [31:0] m_pc;
  logic        m_ack;
  logic [31:0] m_keys    [entries];
  logic [31:0] m_targets [entries];
  logic [entries-1:0] m_valid;
  logic [idx_w-1:0]   m_ptr;

  int val_errs    = 0;
  int other_errs  = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  frontend dut0 (
    .clk             (clk),
    .reset           (reset),
    .fetch_ready     (fetch_ready),
    .res_req         (res_req),
    .res_pc          (res_pc),
    .res_taken       (res_taken),
    .res_target      (res_target),
    .fetch_pc        (fetch_pc),
    .fetch_pred_taken(fetch_pred_taken),
    .res_ack         (res_ack)
  );

  always #50 clk = ~clk;

  // index of a valid entry holding key or -1
  function automatic int find_in_model(input logic [31:0] key);
    int idx;
    idx = -1;
    for (int i = 0; i < entries; i++) begin
      if (m_valid[i] && m_keys[i] == key) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  // what one rising edge does to fetch, the table and ack
  function automatic void step_model();
    logic        act;
    int          a_idx;
    int          b_idx;
    logic [31:0] seq;
    logic [31:0] pred_next;
    logic [31:0] actual_next;
    logic [31:0] next_pc;
    act         = res_req && !m_ack;
    a_idx       = find_in_model(m_pc);
    b_idx       = find_in_model(res_pc);
    seq         = res_pc + pc_step;
    pred_next   = (b_idx >= 0) ? m_targets[b_idx] : seq;
    actual_next = res_taken ? res_target : seq;
    if (act && pred_next != actual_next) begin
      next_pc = actual_next;
    end else if (fetch_ready) begin
      next_pc = (a_idx >= 0) ? m_targets[a_idx] : m_pc + pc_step;
    end else begin
      next_pc = m_pc;
    end
    if (act && res_taken) begin
      if (b_idx >= 0) begin
        m_targets[b_idx] = res_target;  // same slot and the pointer stays
      end else begin
        m_keys[m_ptr]    = res_pc;
        m_targets[m_ptr] = res_target;
        m_valid[m_ptr]   = 1'b1;
        m_ptr            = m_ptr + 1'b1;
      end
    end else if (act && b_idx >= 0) begin
      m_valid[b_idx] = 1'b0;
    end
    if (act) begin
      m_ack = 1'b1;
    end else if (!res_req) begin
      m_ack = 1'b0;
    end
    m_pc = next_pc;
  endfunction

  task automatic check_outputs();
    int idx;
    if (fetch_pc !== m_pc) begin
      $display("ERR fetch_pc: got %h expected %h", fetch_pc, m_pc);
      val_errs++;
      m_pc = fetch_pc;  // resync model
    end
    idx = find_in_model(m_pc);
    if (fetch_pred_taken !== (idx >= 0)) begin
      $display("ERR fetch_pred_taken: got %h expected %h", fetch_pred_taken, idx >= 0);
      val_errs++;
    end
    if (res_ack !== m_ack) begin
      $display("ERR res_ack: got %h expected %h", res_ack, m_ack);
      val_errs++;
    end
  endtask

  // check mid-cycle and step the model, then return 1 unit past the edge
  task automatic tick();
    @(negedge clk);
    check_outputs();
    step_model();
    @(posedge clk);
    #1;
  endtask

  task automatic stall_run(input int unsigned cycles, input logic [31:0] mode);
    for (int unsigned i = 0; i < cycles; i++) begin
      if (mode == 32'd2) begin
        fetch_ready = 1'($urandom & 1);
      end else begin
        fetch_ready = mode[0];
      end
      tick();
    end
  endtask

  task automatic wait_fetch(input logic [31:0] pc, input logic pred);
    int n;
    n = 0;
    fetch_ready = 1'b1;
    while (fetch_pc !== pc && n < walk_limit) begin
      tick();
      n++;
    end
    if (fetch_pc !== pc) begin
      $display("fetch never reached pc %h within %0d cycles", pc, walk_limit);
      other_errs++;
    end else if (fetch_pred_taken !== pred) begin
      $display("ERR fetch_pred_taken at pc %h: got %h expected %h", pc, fetch_pred_taken, pred);
      val_errs++;
    end
  endtask

  // one four-phase resolution that leaves fetch_ready alone
  task automatic resolve(input logic [31:0] pc, input logic taken, input logic [31:0] target);
    int n;
    res_pc     = pc;
    res_taken  = taken;
    res_target = target;
    res_req    = 1'b1;
    tick();
    n = 1;
    while (res_ack !== 1'b1 && n < ack_limit) begin
      tick();
      n++;
    end
    if (res_ack !== 1'b1) begin
      $display("resolution of pc %h was never acknowledged", pc);
      other_errs++;
    end
    res_req = 1'b0;
    tick();
    n = 1;
    while (res_ack !== 1'b0 && n < ack_limit) begin
      tick();
      n++;
    end
    if (res_ack !== 1'b0) begin
      $display("res_ack for pc %h stayed high after the request dropped", pc);
      other_errs++;
    end
  endtask

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("run stopped at the cycle limit of %0d before the stimulus ended", cycle_limit);
      $display("errors: %0d value, %0d other", val_errs, other_errs + 1);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin : main
    int          nrec;
    logic [7:0]  base;
    clk         = 1'b0;
    reset       = 1'b1;
    fetch_ready = 1'b0;
    res_req     = 1'b0;
    res_pc      = '0;
    res_taken   = 1'b0;
    res_target  = '0;
    void'($urandom(63));
    stim        = '{default: '0};
    $readmemh("dv/btb_stimulus.txt", stim);
    nrec = 0;
    while (nrec < max_records && stim[8'(4 * nrec)] != 32'd0) begin
      nrec++;
    end
    cycle_limit = 40 * nrec + 100;
    m_pc    = reset_vector;
    m_ack   = 1'b0;
    m_valid = '0;
    m_ptr   = '0;
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int r = 0; r < nrec; r++) begin
      base = 8'(4 * r);
      case (stim[base])
        32'd1: resolve(stim[base + 8'd1], stim[base + 8'd2][0], stim[base + 8'd3]);
        32'd2: stall_run(stim[base + 8'd1], stim[base + 8'd2]);
        32'd3: wait_fetch(stim[base + 8'd1], stim[base + 8'd2][0]);
        default: begin
          $display("stimulus record %0d has an unknown kind", r);
          other_errs++;
        end
      endcase
    end
    tick();  // last compare
    $display("errors: %0d value, %0d other", val_errs, other_errs);
    if (val_errs + other_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/btb_stimulus.txt
// columns: kind arg1 arg2 arg3, hex; kind 1 resolution (pc taken target),
// kind 2 stall run (cycles, mode 0 low 1 high 2 random), kind 3 fetch check (pc pred_taken)
2 0000000a 1 0          // walk from reset vector
2 00000004 0 0          // fetch holds
2 0000000c 2 0
1 00000140 1 00000100   // taken, BTB miss
3 00000140 1 0
3 00000100 0 0
1 00000130 1 00000138   // forward branch
3 00000130 1 0
3 00000138 0 0
1 00000140 1 00000120   // new target, same slot
3 00000140 1 0
3 00000120 0 0
1 00000300 1 00000120
1 00000304 1 00000120
2 00000003 0 0          // resolve with decode stalled
1 00000308 1 00000120
1 0000030c 1 00000120
1 00000310 1 00000120
1 00000314 1 00000120
1 00000318 1 00000120   // ninth branch wraps onto 0x140
3 00000140 0 0
3 00000144 0 0
2 00000003 0 0
1 00000130 0 00000000   // predicted taken, went straight
3 00000134 0 0
2 00000002 0 0
1 00000318 1 00000120   // correct prediction
1 00000200 0 00000000
3 00000134 0 0
3 00000140 0 0
2 00000010 2 0

// File: filelist.f
hw/isa_pkg.sv
hw/btb_pkg.sv
hw/btb.sv
hw/pc_gen.sv
hw/btb_update.sv
hw/frontend.sv
dv/frontend_sva.sv
dv/frontend_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module frontend_tb -f filelist.f -Mdir obj_dir
	./obj_dir/Vfrontend_tb | tee /dev/stderr | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
